// File: dv/lcd_panel_model.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_panel_model #(
    parameter int H_RES = 96,
    parameter int V_RES = 40
) (
    input logic              clk_20MHz,
    input tft_pkg::lcd_bus_t lcd,
    input logic              lcd_rst_n,
    input logic              backlight
);
    import tft_pkg::*;

    logic [15:0] fb [H_RES*V_RES];
    logic [7:0]  cmd_log [8];
    int          n_cmds;
    int          errors;
    logic        bl_at_disp;

    // Window and write pointer
    int        xs, xe, ys, ye, px, py;
    // 1 column params, 2 row params
    int        par_kind;
    int        par_idx;
    bit        pixel_mode;

    // Write cycle tracking
    logic      prev_cs, prev_wr, cyc_rs;
    lcd_word_u cyc_data;
    int        low_cnt;

    initial begin
        errors  = 0;
        n_cmds  = 0;
        prev_cs = 1'b1;
        prev_wr = 1'b1;
    end

    task automatic accept_word(input logic rs, input lcd_word_u data);
        int v;
        v = int'(data);
        if (!rs) begin
            // Command view
            if (n_cmds < 8) cmd_log[n_cmds] = data.cmd.code;
            n_cmds++;
            pixel_mode = 0;
            par_idx    = 0;
            par_kind   = 0;
            case (data.cmd.code)
                CMD_COLUMN_SET: par_kind = 1;
                CMD_ROW_SET:    par_kind = 2;
                CMD_MEMORY_WRITE: begin
                    pixel_mode = 1;
                    px         = xs;
                    py         = ys;
                end
                CMD_DISPLAY_ON: bl_at_disp = backlight;
                default: ;
            endcase
        end else if (par_kind != 0) begin
            // Parameters as plain numbers
            if (par_kind == 1) begin
                if (par_idx == 0) xs = v;
                else xe = v;
            end else begin
                if (par_idx == 0) ys = v;
                else ye = v;
            end
            par_idx++;
            if (par_idx == 2) par_kind = 0;
        end else if (pixel_mode) begin
            assert (py <= ye && px <= xe && xe < H_RES && ye < V_RES) else begin
                $display("Pixel written outside the declared window at %0d,%0d", px, py);
                errors++;
            end
            if (py <= ye && px <= xe && xe < H_RES && ye < V_RES) begin
                fb[py*H_RES+px] = data;
            end
            px++;
            // Wrap inside the window
            if (px > xe) begin
                px = xs;
                py++;
            end
        end else begin
            $display("Data word arrived without a command before it");
            errors++;
        end
    endtask

    always @(posedge clk_20MHz) begin
        // Panel ignores the bus while held in reset
        if (lcd_rst_n !== 1'b1) begin
            for (int i = 0; i < H_RES*V_RES; i++) fb[i] = '0;
            n_cmds     = 0;
            par_kind   = 0;
            pixel_mode = 0;
            bl_at_disp = 1'b0;
            xs = 0;
            xe = 0;
            ys = 0;
            ye = 0;
        end else begin
            // Cycle shape
            if (!lcd.cs_n) begin
                if (prev_cs) begin
                    cyc_rs   = lcd.rs;
                    cyc_data = lcd.data;
                    low_cnt  = 0;
                end else begin
                    assert (lcd.rs == cyc_rs && lcd.data == cyc_data) else begin
                        $display("FAILED lcd.data %h rs %h changed to %h rs %h in a write cycle",
                                 cyc_data, cyc_rs, lcd.data, lcd.rs);
                        errors++;
                    end
                end
                if (!lcd.wr_n) low_cnt++;
            end else begin
                if (!prev_cs) begin
                    assert (low_cnt == 1) else begin
                        $display("FAILED lcd.wr_n low clocks = %h, expected %h", low_cnt, 1);
                        errors++;
                    end
                end
                assert (lcd.wr_n) else begin
                    $display("Write strobe went low while chip select was inactive");
                    errors++;
                end
            end
            assert (lcd.rd_n) else begin
                $display("FAILED lcd.rd_n = %h, expected %h", lcd.rd_n, 1'b1);
                errors++;
            end
            // Panel samples on the wr_n rising edge
            if (!lcd.cs_n && lcd.wr_n && !prev_wr) accept_word(lcd.rs, lcd.data);
        end
        prev_cs = lcd.cs_n;
        prev_wr = lcd.wr_n;
    end

endmodule

`default_nettype wire

// File: dv/tb_single_photon_counter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_single_photon_counter;
    import tft_pkg::*;

    localparam int h_res = 96;
    localparam int v_res = 40;
    localparam int ticks = 300;
    localparam int hold  = 10;
    localparam int limit = 40000;

    logic     clk_20MHz;
    logic     rst_n;
    lcd_bus_t lcd;
    logic     lcd_rst_n;
    logic     backlight;

    int errors, tests, tests_failed, err_mark, prev_time, cyc, cap_secs, seed_val;
    bit aborted, armed;
    logic prev_cs;

    single_photon_counter #(
        .H_RES (h_res), .V_RES (v_res), .TICKS_PER_SEC (ticks), .RST_HOLD_CYCLES (hold)
    ) dut_i (
        .clk_20MHz (clk_20MHz), .rst_n (rst_n), .lcd_rst_n (lcd_rst_n),
        .backlight (backlight), .lcd (lcd)
    );

    lcd_panel_model #(.H_RES (h_res), .V_RES (v_res)) panel_i (
        .clk_20MHz (clk_20MHz), .lcd (lcd), .lcd_rst_n (lcd_rst_n), .backlight (backlight)
    );

    initial begin
        clk_20MHz = 1'b0;
        forever #25 clk_20MHz = ~clk_20MHz;
    end

    // Reference seconds counter, and time at each draw's first command
    always @(posedge clk_20MHz or negedge rst_n) begin
        if (!rst_n) begin
            cyc     <= 0;
            armed   <= 1'b1;
            prev_cs <= 1'b1;
        end else begin
            cyc     <= cyc + 1;
            prev_cs <= lcd.cs_n;
            if (dut_i.done) begin
                armed <= 1'b1;
            end else if (armed && prev_cs && !lcd.cs_n) begin
                cap_secs <= cyc / ticks;
                armed    <= 1'b0;
            end
        end
    end

    function automatic int total_errors();
        return errors + panel_i.errors;
    endfunction

    task automatic finish_test(input string name);
        tests++;
        if (total_errors() == err_mark) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed", name);
        end
        err_mark = total_errors();
    endtask

    task automatic check_bus_idle();
        assert (!lcd_rst_n && !backlight && lcd.cs_n && lcd.wr_n) else begin
            $display("FAILED lcd_rst_n %h backlight %h cs_n %h wr_n %h, expected 0 0 1 1",
                     lcd_rst_n, backlight, lcd.cs_n, lcd.wr_n);
            errors++;
        end
    endtask

    // Reset, then the panel reset hold
    task automatic apply_reset(input int n);
        int k;
        @(negedge clk_20MHz);
        rst_n = 1'b0;
        repeat (n) begin
            @(negedge clk_20MHz);
            check_bus_idle();
        end
        rst_n = 1'b1;
        k = 0;
        while (!lcd_rst_n && k < 100) begin
            check_bus_idle();
            @(negedge clk_20MHz);
            k++;
        end
        if (!lcd_rst_n) begin
            $display("Timeout waiting for the panel reset to end");
            errors++;
            aborted = 1;
        end
    endtask

    task automatic check_init();
        int k;
        k = 0;
        while (panel_i.n_cmds < 2 && k < 200) begin
            @(negedge clk_20MHz);
            k++;
        end
        if (panel_i.n_cmds < 2) begin
            $display("Timeout waiting for the init commands");
            errors++;
            aborted = 1;
            return;
        end
        assert (panel_i.cmd_log[0] == CMD_SLEEP_OUT && panel_i.cmd_log[1] == CMD_DISPLAY_ON)
        else begin
            $display("FAILED init commands = %h %h, expected %h %h", panel_i.cmd_log[0],
                     panel_i.cmd_log[1], CMD_SLEEP_OUT, CMD_DISPLAY_ON);
            errors++;
        end
        assert (!panel_i.bl_at_disp) else begin
            $display("FAILED backlight = %h at display-on, expected %h", 1'b1, 1'b0);
            errors++;
        end
        k = 0;
        while (!backlight && k < 20) begin
            @(negedge clk_20MHz);
            k++;
        end
        assert (backlight) else begin
            $display("Backlight did not turn on after display-on");
            errors++;
        end
    endtask

    task automatic wait_done(input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk_20MHz);
            n++;
        end while (!dut_i.done && n < limit);
        if (!dut_i.done) begin
            $display("Timeout waiting for the %s draw to finish", what);
            errors++;
            aborted = 1;
        end
    endtask

    task automatic check_px(input int x, input int y, input rgb565_t exp);
        logic [15:0] got;
        got = panel_i.fb[y*h_res+x];
        assert (got == exp) else begin
            $display("FAILED panel pixel %0d,%0d = %h, expected %h", x, y, got, exp);
            errors++;
        end
    endtask

    // Trace row from the sine rule, rounded half away from zero
    function automatic int sine_row(input int x);
        real a;
        a = 15.0 * $sin(2.0 * 3.14159265358979 * (x % 64) / 64.0);
        if (a >= 0.0) return v_res / 2 - $rtoi(a + 0.5);
        return v_res / 2 + $rtoi(-a + 0.5);
    endfunction

    function automatic logic [16:0] encode_time(input int s);
        logic [16:0] t;
        t[16:12] = 5'((s / 3600) % 24);
        t[11:6]  = 6'((s / 60) % 60);
        t[5:0]   = 6'(s % 60);
        return t;
    endfunction

    task automatic check_screen(input bit with_sine);
        rgb565_t exp;
        for (int y = 0; y < v_res; y++) begin
            for (int x = 0; x < h_res; x++) begin
                exp = (y == v_res / 2) ? COLOR_AXIS : COLOR_BG;
                if (with_sine && y == sine_row(x)) exp = COLOR_TRACE;
                check_px(x, y, exp);
            end
        end
    endtask

    task automatic check_clock();
        logic [16:0] bits;
        logic [15:0] got;
        int t, e;
        bits = '0;
        for (int i = 0; i < 17; i++) begin
            got = panel_i.fb[CLOCK_Y0*h_res + CLOCK_X0 + i*CELL_PITCH];
            if (got == COLOR_BIT_ON) begin
                bits[16-i] = 1'b1;
            end else if (got != COLOR_BIT_OFF) begin
                $display("Clock cell %0d shows neither bit colour", i);
                errors++;
            end
            // Whole cell in one colour
            for (int d = 0; d < CELL_SIZE*CELL_SIZE; d++) begin
                check_px(CLOCK_X0 + i*CELL_PITCH + d % CELL_SIZE, CLOCK_Y0 + d / CELL_SIZE,
                         rgb565_t'(got));
            end
        end
        e = cap_secs;
        assert (bits == encode_time(e) || bits == encode_time(e > 0 ? e - 1 : e)) else begin
            $display("FAILED clock cells = %h, expected %h or %h", bits, encode_time(e),
                     encode_time(e > 0 ? e - 1 : e));
            errors++;
        end
        t = bits[16:12] * 3600 + bits[11:6] * 60 + bits[5:0];
        assert (t > prev_time) else begin
            $display("Clock redraw did not advance the time");
            errors++;
        end
        prev_time = t;
    endtask

    task automatic run_pass(input int r, input int rst_len);
        prev_time = -1;
        apply_reset(rst_len);
        finish_test($sformatf("pass %0d idle after reset", r));
        if (aborted) return;
        check_init();
        finish_test($sformatf("pass %0d panel init", r));
        if (aborted) return;
        wait_done("fixed parts");
        if (aborted) return;
        check_screen(1'b0);
        finish_test($sformatf("pass %0d fixed parts", r));
        wait_done("sine");
        if (aborted) return;
        check_screen(1'b1);
        finish_test($sformatf("pass %0d sine trace", r));
        for (int k = 0; k < 3; k++) begin
            wait_done("clock");
            if (aborted) return;
            check_clock();
            finish_test($sformatf("pass %0d clock draw %0d", r, k));
        end
    endtask

    initial begin
        rst_n        = 1'b1;
        errors       = 0;
        tests        = 0;
        tests_failed = 0;
        err_mark     = 0;
        aborted      = 0;
        seed_val     = $urandom(90943);
        run_pass(0, 5);
        // Two more resets dropped into a running redraw
        for (int r = 1; r < 3 && !aborted; r++) begin
            repeat ($urandom_range(1200, 20)) @(negedge clk_20MHz);
            run_pass(r, $urandom_range(20, 1));
        end
        $display("%0d tests, %0d failed, %0d errors", tests, tests_failed, total_errors());
        if (total_errors() == 0 && !aborted) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hdl/tft_pkg.sv
hdl/lcd_bus_writer.sv
hdl/sine_rom.sv
hdl/rtc_counter.sv
hdl/screen_painter.sv
hdl/tft_adapter.sv
hdl/single_photon_counter.sv
dv/lcd_panel_model.sv
dv/tb_single_photon_counter.sv

// File: hdl/lcd_bus_writer.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_writer (
    input  logic               clk_20MHz,
    input  logic               rst_n,
    input  logic               wr_req,
    input  logic               wr_rs,
    input  tft_pkg::lcd_word_u wr_word,
    output logic               wr_done,
    output tft_pkg::lcd_bus_t  lcd
);
    import tft_pkg::*;

    // Pins between write cycles
    localparam lcd_bus_t bus_idle = '{
        cs_n: 1'b1,
        rs:   1'b1,
        wr_n: 1'b1,
        rd_n: 1'b1,
        data: '0
    };

    // One state per clock of the write cycle
    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_strobe,
        st_release
    } state_e;

    state_e state;

    // Done in the clock where wr_n goes back high
    assign wr_done = (state == st_release);

    always_ff @(posedge clk_20MHz or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            lcd   <= bus_idle;
        end else begin
            case (state)
                st_idle: begin
                    // Word and rs held until the panel has sampled them
                    if (wr_req) begin
                        lcd.cs_n <= 1'b0;
                        lcd.rs   <= wr_rs;
                        lcd.data <= wr_word;
                        state    <= st_setup;
                    end
                end
                st_setup: begin
                    lcd.wr_n <= 1'b0;
                    state    <= st_strobe;
                end
                st_strobe: begin
                    // Panel latches on this rising edge
                    lcd.wr_n <= 1'b1;
                    state    <= st_release;
                end
                default: begin
                    lcd   <= bus_idle;
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/rtc_counter.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_counter #(
    parameter int TICKS_PER_SEC = 20_000_000
) (
    input  logic               clk_20MHz,
    input  logic               rst_n,
    output tft_pkg::rtc_time_t now,
    output logic               sec_tick
);

    localparam int pre_w = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;

    logic [pre_w-1:0] pre_cnt;
    logic             sec_wrap;

    // Last clock of the current second
    assign sec_wrap = (pre_cnt == pre_w'(TICKS_PER_SEC - 1));

    always_ff @(posedge clk_20MHz or negedge rst_n) begin
        if (!rst_n) begin
            pre_cnt  <= '0;
            now      <= '0;
            sec_tick <= 1'b0;
        end else begin
            // Tick lines up with the new seconds value
            sec_tick <= sec_wrap;
            if (sec_wrap) begin
                pre_cnt <= '0;
                if (now.seconds != 6'd59) begin
                    now.seconds <= now.seconds + 6'd1;
                end else begin
                    now.seconds <= '0;
                    if (now.minutes != 6'd59) begin
                        now.minutes <= now.minutes + 6'd1;
                    end else begin
                        now.minutes <= '0;
                        // Day wrap
                        now.hours   <= (now.hours == 5'd23) ? 5'd0 : now.hours + 5'd1;
                    end
                end
            end else begin
                pre_cnt <= pre_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/screen_painter.sv
`timescale 1ns/1ps
`default_nettype none

module screen_painter #(
    parameter int H_RES = 480,
    parameter int V_RES = 272
) (
    input  logic               clk_20MHz,
    input  logic               rst_n,
    input  logic               start,
    input  tft_pkg::draw_cmd_e cmd,
    input  tft_pkg::rtc_time_t now,
    output logic               wr_req,
    output logic               wr_rs,
    output tft_pkg::lcd_word_u wr_word,
    input  logic               wr_done,
    output logic               busy
);
    import tft_pkg::*;

    localparam int          pix_w       = $clog2(H_RES * V_RES + 1);
    localparam int          clock_cells = $bits(rtc_time_t);
    localparam logic [15:0] x_last      = 16'(H_RES - 1);
    localparam logic [15:0] y_last      = 16'(V_RES - 1);
    localparam logic [15:0] y_mid       = 16'(V_RES / 2);

    // Step 7 streams pixels, steps 0 to 6 carry the window commands
    localparam logic [2:0] step_pixels = 3'd7;

    draw_cmd_e        mode;
    rtc_time_t        time_q;
    logic [15:0]      win;
    logic [2:0]       step;
    logic [pix_w-1:0] pix;

    // Current window
    logic [15:0]       xs;
    logic [15:0]       xe;
    logic [15:0]       ys;
    logic [15:0]       ye;
    rgb565_t           color;
    logic [pix_w-1:0]  npix;
    logic              last_win;

    logic [5:0]        phase;
    logic signed [4:0] sample;
    logic [15:0]       cell_x;
    logic [16:0]       time_bits;
    logic [4:0]        bit_idx;

    ////////////////////////////////////////
    // Window geometry
    ////////////////////////////////////////

    // Trace repeats every period along x
    assign phase     = 6'(win % SINE_PERIOD);
    assign cell_x    = 16'(CLOCK_X0 + win * CELL_PITCH);
    assign time_bits = time_q;
    // Leftmost cell shows the hours MSB
    assign bit_idx   = 5'(clock_cells - 1) - win[4:0];

    sine_rom sine_rom_i (
        .phase  (phase),
        .sample (sample)
    );

    always_comb begin
        xs       = '0;
        xe       = x_last;
        ys       = '0;
        ye       = y_last;
        color    = COLOR_BG;
        npix     = pix_w'(H_RES * V_RES);
        last_win = 1'b0;
        case (mode)
            draw_fixed: begin
                // Second window is the centre axis row
                if (win != '0) begin
                    ys       = y_mid;
                    ye       = y_mid;
                    color    = COLOR_AXIS;
                    npix     = pix_w'(H_RES);
                    last_win = 1'b1;
                end
            end
            draw_sine: begin
                // Single pixel per column, positive samples go up
                xs       = win;
                xe       = win;
                ys       = y_mid - {{11{sample[4]}}, sample};
                ye       = y_mid - {{11{sample[4]}}, sample};
                color    = COLOR_TRACE;
                npix     = pix_w'(1);
                last_win = (win == x_last);
            end
            draw_rtc: begin
                xs       = cell_x;
                xe       = cell_x + 16'(CELL_SIZE - 1);
                ys       = 16'(CLOCK_Y0);
                ye       = 16'(CLOCK_Y0 + CELL_SIZE - 1);
                color    = time_bits[bit_idx] ? COLOR_BIT_ON : COLOR_BIT_OFF;
                npix     = pix_w'(CELL_SIZE * CELL_SIZE);
                last_win = (win == 16'(clock_cells - 1));
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // Word stream to the writer
    ////////////////////////////////////////

    assign wr_req = busy && (mode != draw_idle);

    always_comb begin
        wr_word = '0;
        wr_rs   = 1'b1;
        case (step)
            3'd0: begin
                wr_rs            = 1'b0;
                wr_word.cmd.code = CMD_COLUMN_SET;
            end
            3'd1: wr_word = lcd_word_u'(xs);
            3'd2: wr_word = lcd_word_u'(xe);
            3'd3: begin
                wr_rs            = 1'b0;
                wr_word.cmd.code = CMD_ROW_SET;
            end
            3'd4: wr_word = lcd_word_u'(ys);
            3'd5: wr_word = lcd_word_u'(ye);
            3'd6: begin
                wr_rs            = 1'b0;
                wr_word.cmd.code = CMD_MEMORY_WRITE;
            end
            default: wr_word.color = color;
        endcase
    end

    // Clock frozen for the whole redraw
    always_ff @(posedge clk_20MHz) begin
        if (start && !busy) begin
            time_q <= now;
        end
    end

    always_ff @(posedge clk_20MHz or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            mode <= draw_idle;
            win  <= '0;
            step <= '0;
            pix  <= '0;
        end else if (!busy) begin
            if (start) begin
                busy <= 1'b1;
                mode <= cmd;
                win  <= '0;
                step <= '0;
                pix  <= '0;
            end
        end else if (mode == draw_idle) begin
            // Nothing to paint
            busy <= 1'b0;
        end else if (wr_done) begin
            if (step != step_pixels) begin
                step <= step + 3'd1;
                pix  <= '0;
            end else if (pix != npix - 1'b1) begin
                pix <= pix + 1'b1;
            end else if (last_win) begin
                busy <= 1'b0;
            end else begin
                // Next window
                win  <= win + 16'd1;
                step <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/sine_rom.sv
`timescale 1ns/1ps
`default_nettype none

module sine_rom (
    input  logic [5:0]        phase,
    output logic signed [4:0] sample
);

    // First quarter of the period at amplitude 15
    localparam logic [3:0] quarter [17] = '{
        4'd0,  4'd1,  4'd3,  4'd4,
        4'd6,  4'd7,  4'd8,  4'd10,
        4'd11, 4'd12, 4'd12, 4'd13,
        4'd14, 4'd14, 4'd15, 4'd15,
        4'd15
    };

    logic [4:0] idx;
    logic [3:0] mag;

    // Second and fourth quarters read the table backwards
    assign idx = phase[4] ? 5'd16 - {1'b0, phase[3:0]} : {1'b0, phase[3:0]};
    assign mag = quarter[idx];

    // Lower half of the period
    assign sample = phase[5] ? -$signed({1'b0, mag}) : $signed({1'b0, mag});

endmodule

`default_nettype wire

// File: hdl/single_photon_counter.sv
`timescale 1ns/1ps
`default_nettype none

module single_photon_counter #(
    parameter int H_RES           = 480,
    parameter int V_RES           = 272,
    parameter int TICKS_PER_SEC   = 20_000_000,
    parameter int RST_HOLD_CYCLES = 200
) (
    input  logic              clk_20MHz,
    input  logic              rst_n,
    output logic              lcd_rst_n,
    output logic              backlight,
    output tft_pkg::lcd_bus_t lcd
);
    import tft_pkg::*;

    typedef enum logic [1:0] {
        step_fixed,
        step_sine,
        step_rtc,
        step_wait
    } step_e;

    step_e     step;
    logic      en;
    logic      en_d;
    draw_cmd_e trigger;
    logic      done;
    rtc_time_t now;
    logic      sec_tick;
    logic      tick_pend;

    rtc_counter #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) rtc_i (
        .clk_20MHz (clk_20MHz),
        .rst_n     (rst_n),
        .now       (now),
        .sec_tick  (sec_tick)
    );

    tft_adapter #(
        .H_RES           (H_RES),
        .V_RES           (V_RES),
        .RST_HOLD_CYCLES (RST_HOLD_CYCLES)
    ) adapter_i (
        .clk_20MHz (clk_20MHz),
        .rst_n     (rst_n),
        .en        (en),
        .trigger   (trigger),
        .now       (now),
        .done      (done),
        .lcd_rst_n (lcd_rst_n),
        .backlight (backlight),
        .lcd       (lcd)
    );

    ////////////////////////////////////////
    // Drawing step sequencer
    ////////////////////////////////////////

    always_ff @(posedge clk_20MHz or negedge rst_n) begin
        if (!rst_n) begin
            step    <= step_fixed;
            en      <= 1'b0;
            trigger <= draw_idle;
        end else begin
            case (step)
                step_fixed: begin
                    if (done) begin
                        en   <= 1'b0;
                        step <= step_sine;
                    end else begin
                        en      <= 1'b1;
                        trigger <= draw_fixed;
                    end
                end
                step_sine: begin
                    if (done) begin
                        en   <= 1'b0;
                        step <= step_rtc;
                    end else begin
                        en      <= 1'b1;
                        trigger <= draw_sine;
                    end
                end
                step_rtc: begin
                    if (done) begin
                        en   <= 1'b0;
                        step <= step_wait;
                    end else begin
                        en      <= 1'b1;
                        trigger <= draw_rtc;
                    end
                end
                default: begin
                    // Clock redraw per second
                    if (en) begin
                        if (done) en <= 1'b0;
                    end else if (tick_pend || sec_tick) begin
                        en      <= 1'b1;
                        trigger <= draw_rtc;
                    end
                end
            endcase
        end
    end

    // A tick in the first clock of en is still caught by the painter's latch,
    // only later ones need a redraw
    always_ff @(posedge clk_20MHz or negedge rst_n) begin
        if (!rst_n) begin
            en_d      <= 1'b0;
            tick_pend <= 1'b0;
        end else begin
            en_d <= en;
            if (sec_tick && en && en_d && (step == step_rtc || step == step_wait)) begin
                tick_pend <= 1'b1;
            end else if (step == step_wait && !en) begin
                tick_pend <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/tft_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module tft_adapter #(
    parameter int H_RES           = 480,
    parameter int V_RES           = 272,
    parameter int RST_HOLD_CYCLES = 200
) (
    input  logic               clk_20MHz,
    input  logic               rst_n,
    input  logic               en,
    input  tft_pkg::draw_cmd_e trigger,
    input  tft_pkg::rtc_time_t now,
    output logic               done,
    output logic               lcd_rst_n,
    output logic               backlight,
    output tft_pkg::lcd_bus_t  lcd
);
    import tft_pkg::*;

    localparam int hold_w = $clog2(RST_HOLD_CYCLES + 1);

    typedef enum logic [2:0] {
        st_hold,
        st_sleep,
        st_disp,
        st_ready,
        st_draw,
        st_done
    } state_e;

    state_e           state;
    logic [hold_w-1:0] hold_cnt;
    logic             start;

    // Painter side of the word mux
    logic             paint_req;
    logic             paint_rs;
    lcd_word_u        paint_word;
    logic             paint_busy;

    // Writer side of the word mux
    logic             wr_req;
    logic             wr_rs;
    lcd_word_u        wr_word;
    logic             wr_done;

    // Requests during init stay pending on en
    assign start = (state == st_ready) && en;
    assign done  = (state == st_done);

    screen_painter #(
        .H_RES (H_RES),
        .V_RES (V_RES)
    ) painter_i (
        .clk_20MHz (clk_20MHz),
        .rst_n     (rst_n),
        .start     (start),
        .cmd       (trigger),
        .now       (now),
        .wr_req    (paint_req),
        .wr_rs     (paint_rs),
        .wr_word   (paint_word),
        .wr_done   (wr_done),
        .busy      (paint_busy)
    );

    // Init commands own the writer until the panel is on
    always_comb begin
        wr_req  = paint_req;
        wr_rs   = paint_rs;
        wr_word = paint_word;
        if (state == st_sleep || state == st_disp) begin
            wr_req           = 1'b1;
            wr_rs            = 1'b0;
            wr_word          = '0;
            wr_word.cmd.code = (state == st_sleep) ? CMD_SLEEP_OUT : CMD_DISPLAY_ON;
        end
    end

    lcd_bus_writer writer_i (
        .clk_20MHz (clk_20MHz),
        .rst_n     (rst_n),
        .wr_req    (wr_req),
        .wr_rs     (wr_rs),
        .wr_word   (wr_word),
        .wr_done   (wr_done),
        .lcd       (lcd)
    );

    always_ff @(posedge clk_20MHz or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_hold;
            hold_cnt  <= '0;
            lcd_rst_n <= 1'b0;
            backlight <= 1'b0;
        end else begin
            case (state)
                st_hold: begin
                    // Panel reset pulse
                    if (hold_cnt == hold_w'(RST_HOLD_CYCLES - 1)) begin
                        lcd_rst_n <= 1'b1;
                        state     <= st_sleep;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                st_sleep: if (wr_done) state <= st_disp;
                st_disp: begin
                    // Light only once the display is on
                    if (wr_done) begin
                        backlight <= 1'b1;
                        state     <= st_ready;
                    end
                end
                st_ready: if (en) state <= st_draw;
                // Busy is already up here, so low means finished
                st_draw:  if (!paint_busy) state <= st_done;
                default:  state <= st_ready;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/tft_pkg.sv
`default_nettype none

package tft_pkg;

    ////////////////////////////////////////
    // Panel bus types
    ////////////////////////////////////////

    // RGB565 pixel
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // Command word with the high byte left at zero
    typedef struct packed {
        logic [7:0] zero;
        logic [7:0] code;
    } lcd_cmd_t;

    // One data word, read by rs
    // rs low selects the command view
    typedef union packed {
        lcd_cmd_t cmd;
        rgb565_t  color;
    } lcd_word_u;

    // 8080 panel pins
    typedef struct packed {
        logic      cs_n;
        logic      rs;
        logic      wr_n;
        logic      rd_n;
        lcd_word_u data;
    } lcd_bus_t;

    // Draw requests from the sequencer
    typedef enum logic [1:0] {
        draw_idle,
        draw_fixed,
        draw_sine,
        draw_rtc
    } draw_cmd_e;

    // Hours in the top bits
    typedef struct packed {
        logic [4:0] hours;
        logic [5:0] minutes;
        logic [5:0] seconds;
    } rtc_time_t;

    ////////////////////////////////////////
    // Panel command codes
    ////////////////////////////////////////

    localparam logic [7:0] CMD_SLEEP_OUT    = 8'h11;
    localparam logic [7:0] CMD_DISPLAY_ON   = 8'h29;
    localparam logic [7:0] CMD_COLUMN_SET   = 8'h2A;
    localparam logic [7:0] CMD_ROW_SET      = 8'h2B;
    localparam logic [7:0] CMD_MEMORY_WRITE = 8'h2C;

    // Screen colours
    localparam rgb565_t COLOR_BG      = '{red: 5'd0,  green: 6'd0,  blue: 5'd6};
    localparam rgb565_t COLOR_AXIS    = '{red: 5'd16, green: 6'd32, blue: 5'd16};
    localparam rgb565_t COLOR_TRACE   = '{red: 5'd31, green: 6'd63, blue: 5'd0};
    localparam rgb565_t COLOR_BIT_ON  = '{red: 5'd0,  green: 6'd63, blue: 5'd0};
    localparam rgb565_t COLOR_BIT_OFF = '{red: 5'd10, green: 6'd0,  blue: 5'd0};

    ////////////////////////////////////////
    // Screen layout
    ////////////////////////////////////////

    // Clock cells, side and spacing in pixels
    localparam int CELL_SIZE   = 4;
    localparam int CELL_PITCH  = 5;
    // Top left corner of the clock row
    localparam int CLOCK_X0    = 2;
    localparam int CLOCK_Y0    = 2;
    // Trace height and repeat length
    localparam int SINE_AMPL   = 15;
    localparam int SINE_PERIOD = 64;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e

verilator --binary --timing -Wno-fatal \
    -f files.f \
    --top-module tb_single_photon_counter \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0
